/* hw/rs_macros.svh */
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// number of station slots
`define RS_DEPTH 8

// common data bus lanes snooped for wakeup
`define CDB_WIDTH 2

// physical register tag width
`define PHY_W 6

// immediate carried in the src2 word
`define IMM_W 12

// alu operation code
`define OP_W 4

// slot index width for RS_DEPTH slots
`define RS_IDX_W $clog2(`RS_DEPTH)

// bypass enable width, cdb lanes plus the fast path on top
`define BYP_W (`CDB_WIDTH + 1)

`endif

/* hw/int_rs_pkg.sv */
`include "rs_macros.svh"

package int_rs_pkg;

    // physical register tag
    typedef logic [`PHY_W-1:0] phy_t;

    // src2 word read as a register source
    // pad keeps the view as wide as the immediate
    typedef struct packed {
        logic [`IMM_W-`PHY_W-2:0] pad;
        logic                     rs2_valid;
        phy_t                     rs2_phy;
    } src2_tag_t;

    // one word, two decodes, picked by use_imm
    typedef union packed {
        src2_tag_t             tag;
        logic [`IMM_W-1:0]     imm;
    } src2_u;

    // renamed integer micro-op as dispatch hands it over
    typedef struct packed {
        logic [`OP_W-1:0]      op;
        phy_t                  rd_phy;
        phy_t                  rs1_phy;
        logic                  rs1_valid;
        // src2 holds an immediate, second source always ready
        logic                  use_imm;
        src2_u                 src2;
    } int_uop_t;

    // per-source operand forwarding selects for execute
    // low bits are cdb lanes, msb is the fast bypass
    typedef struct packed {
        logic [`BYP_W-1:0]     rs1_bypass_en;
        logic [`BYP_W-1:0]     rs2_bypass_en;
    } bypass_t;

endpackage

/* hw/rs_entry.sv */
`timescale 1ns/1ns
`include "rs_macros.svh"

module rs_entry (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   push_en,
    input  int_rs_pkg::int_uop_t                   entry_in,
    input  logic                                   grant,
    input  logic [`CDB_WIDTH-1:0]                  cdb_valid,
    input  int_rs_pkg::phy_t [`CDB_WIDTH-1:0]      cdb_tag,
    input  logic                                   fast_valid,
    input  int_rs_pkg::phy_t                       fast_tag,
    output logic                                   valid,
    output logic                                   request,
    output int_rs_pkg::int_uop_t                   entry_out,
    output int_rs_pkg::bypass_t                    rs_bypass
);

    logic                    entry_valid;
    int_rs_pkg::int_uop_t    entry_reg;

    // per-lane tag matches against the held sources
    logic [`CDB_WIDTH-1:0]   cdb_hit1;
    logic [`CDB_WIDTH-1:0]   cdb_hit2;
    logic                    fast_hit1;
    logic                    fast_hit2;
    logic                    src1_ready;
    logic                    src2_ready;

    // cdb compare, tag 0 is the zero register and never matches
    // rs2 compare off for immediates so imm bits never look like a tag
    always_comb begin
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            cdb_hit1[k] = cdb_valid[k] && (cdb_tag[k] != '0) &&
                          (cdb_tag[k] == entry_reg.rs1_phy);
            cdb_hit2[k] = cdb_valid[k] && (cdb_tag[k] != '0) && !entry_reg.use_imm &&
                          (cdb_tag[k] == entry_reg.src2.tag.rs2_phy);
        end
    end

    // fast path only counts this cycle, nothing latched from it
    assign fast_hit1 = fast_valid && (fast_tag != '0) &&
                       (fast_tag == entry_reg.rs1_phy);
    assign fast_hit2 = fast_valid && (fast_tag != '0) && !entry_reg.use_imm &&
                       (fast_tag == entry_reg.src2.tag.rs2_phy);

    // fast bypass on the top bit
    assign rs_bypass.rs1_bypass_en = {fast_hit1, cdb_hit1};
    assign rs_bypass.rs2_bypass_en = {fast_hit2, cdb_hit2};

    // held uop with this cycle's cdb wakeups merged in
    always_comb begin
        entry_out = entry_reg;
        if (|cdb_hit1) begin
            entry_out.rs1_valid = 1'b1;
        end
        if (|cdb_hit2) begin
            entry_out.src2.tag.rs2_valid = 1'b1;
        end
    end

    // slot occupancy, push wins over grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= 1'b0;
        end else if (push_en) begin
            entry_valid <= 1'b1;
        end else if (grant) begin
            entry_valid <= 1'b0;
        end
    end

    // payload load on push, else keep snooping the cdb
    always_ff @(posedge clk) begin
        if (push_en) begin
            entry_reg <= entry_in;
        end else begin
            entry_reg <= entry_out;
        end
    end

    // ready if latched or forwarded this cycle
    assign src1_ready = entry_reg.rs1_valid || (|rs_bypass.rs1_bypass_en);
    assign src2_ready = entry_reg.use_imm || entry_reg.src2.tag.rs2_valid ||
                        (|rs_bypass.rs2_bypass_en);

    assign request = entry_valid && src1_ready && src2_ready;
    assign valid   = entry_valid;

endmodule

/* hw/rs_age_select.sv */
`timescale 1ns/1ns
`include "rs_macros.svh"

module rs_age_select (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`RS_DEPTH-1:0]   push,
    input  logic [`RS_DEPTH-1:0]   request,
    input  logic                   grant_en,
    output logic [`RS_DEPTH-1:0]   oldest,
    output logic [`RS_DEPTH-1:0]   grant,
    output logic                   grant_any
);

    // older[r][c] set means slot r was dispatched before slot c
    logic [`RS_DEPTH-1:0][`RS_DEPTH-1:0] older;

    // per slot, some other requester is older
    logic [`RS_DEPTH-1:0]                blocked;

    // pushed slot becomes youngest
    // its row clears, its column sets
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            older <= '0;
        end else if (|push) begin
            for (int r = 0; r < `RS_DEPTH; r++) begin
                for (int c = 0; c < `RS_DEPTH; c++) begin
                    if (push[r]) begin
                        older[r][c] <= 1'b0;
                    end else if (push[c]) begin
                        older[r][c] <= 1'b1;
                    end
                end
            end
        end
    end

    // oldest requester has no older requester
    // stale bits of empty slots are masked by request
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            blocked[i] = 1'b0;
            for (int j = 0; j < `RS_DEPTH; j++) begin
                if ((j != i) && request[j] && older[j][i]) begin
                    blocked[i] = 1'b1;
                end
            end
            oldest[i] = request[i] && !blocked[i];
        end
    end

    // oldest stays visible under back-pressure, grant only with issue_ready
    assign grant     = oldest & {`RS_DEPTH{grant_en}};
    assign grant_any = |request;

endmodule

/* hw/int_rs.sv */
`timescale 1ns/1ns
`include "rs_macros.svh"

module int_rs (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // dispatch side
    input  logic                                   dispatch_valid,
    output logic                                   dispatch_ready,
    input  int_rs_pkg::int_uop_t                   dispatch_uop,

    // wakeup buses
    input  logic [`CDB_WIDTH-1:0]                  cdb_valid,
    input  int_rs_pkg::phy_t [`CDB_WIDTH-1:0]      cdb_tag,
    input  logic                                   fast_valid,
    input  int_rs_pkg::phy_t                       fast_tag,

    // alu issue port
    output logic                                   issue_valid,
    input  logic                                   issue_ready,
    output int_rs_pkg::int_uop_t                   issue_uop,
    output int_rs_pkg::bypass_t                    issue_bypass
);

    logic [`RS_DEPTH-1:0]      slot_valid;
    logic [`RS_DEPTH-1:0]      slot_req;
    logic [`RS_DEPTH-1:0]      free_sel;
    logic [`RS_DEPTH-1:0]      push;
    logic [`RS_DEPTH-1:0]      oldest;
    logic [`RS_DEPTH-1:0]      grant;
    logic                      grant_any;
    logic                      free_found;
    logic [`RS_IDX_W-1:0]      free_idx;

    int_rs_pkg::int_uop_t      slot_uop [`RS_DEPTH];
    int_rs_pkg::bypass_t       slot_byp [`RS_DEPTH];

    // lowest free slot, from registered valids only
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!slot_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = `RS_IDX_W'(i);
            end
        end
    end

    // one-hot of the chosen free slot
    always_comb begin
        free_sel = '0;
        free_sel[free_idx] = free_found;
    end

    assign dispatch_ready = free_found;

    // push only on an accepted transfer
    assign push = (dispatch_valid && dispatch_ready) ? free_sel : '0;

    // station slots
    for (genvar i = 0; i < `RS_DEPTH; i++) begin : slot_g
        rs_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .push_en    (push[i]),
            .entry_in   (dispatch_uop),
            .grant      (grant[i]),
            .cdb_valid  (cdb_valid),
            .cdb_tag    (cdb_tag),
            .fast_valid (fast_valid),
            .fast_tag   (fast_tag),
            .valid      (slot_valid[i]),
            .request    (slot_req[i]),
            .entry_out  (slot_uop[i]),
            .rs_bypass  (slot_byp[i])
        );
    end

    // oldest-ready select, grant held off by alu back-pressure
    rs_age_select age0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .request    (slot_req),
        .grant_en   (issue_ready),
        .oldest     (oldest),
        .grant      (grant),
        .grant_any  (grant_any)
    );

    assign issue_valid = grant_any;

    // issue mux, oldest is one-hot so a plain scan picks it
    // port idles at zero with no request
    always_comb begin
        issue_uop    = '0;
        issue_bypass = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (oldest[i]) begin
                issue_uop    = slot_uop[i];
                issue_bypass = slot_byp[i];
            end
        end
    end

endmodule

/* testbench/int_rs_sva.sv */
`timescale 1ns/1ns
`include "rs_macros.svh"

module int_rs_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`RS_DEPTH-1:0]    push,
    input logic [`RS_DEPTH-1:0]    slot_valid,
    input logic                    issue_valid,
    input logic                    issue_ready,
    input int_rs_pkg::int_uop_t    issue_uop
);

    // failed assertions so far
    int fail_count = 0;

    // issue port quiet after every reset edge
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !issue_valid)
        else begin
            $error("issue_valid high after a reset edge");
            fail_count++;
        end

    // stalled uop stays put while the port keeps requesting
    a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && !issue_ready) ##1 issue_valid |-> $stable(issue_uop))
        else begin
            $error("issue_uop changed under back-pressure");
            fail_count++;
        end

    // full station takes nothing
    // a push never lands on a slot that still holds a uop
    a_push_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        (push & slot_valid) == '0)
        else begin
            $error("dispatch accepted into an occupied slot");
            fail_count++;
        end

endmodule

bind int_rs int_rs_sva sva0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .push           (push),
    .slot_valid     (slot_valid),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_uop      (issue_uop)
);

/* testbench/int_rs_tb.sv */
`timescale 1ns/1ns
`include "rs_macros.svh"

module int_rs_tb;

    localparam int WAIT_LIMIT = 40;

    logic                                clk;
    logic                                rst_n;
    logic                                dispatch_valid;
    logic                                dispatch_ready;
    int_rs_pkg::int_uop_t                dispatch_uop;
    logic [`CDB_WIDTH-1:0]               cdb_valid;
    int_rs_pkg::phy_t [`CDB_WIDTH-1:0]   cdb_tag;
    logic                                fast_valid;
    int_rs_pkg::phy_t                    fast_tag;
    logic                                issue_valid;
    logic                                issue_ready;
    int_rs_pkg::int_uop_t                issue_uop;
    int_rs_pkg::bypass_t                 issue_bypass;

    logic [31:0]                         lfsr_state;
    // issue_ready value applied at the next falling edge
    logic                                ready_next;

    int_rs dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_uop   (dispatch_uop),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .fast_valid     (fast_valid),
        .fast_tag       (fast_tag),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_uop      (issue_uop),
        .issue_bypass   (issue_bypass)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // bound checker failures end the run at the next falling edge
    always @(negedge clk) begin
        if (dut0.sva0.fail_count != 0) begin
            $display("assertion failure in the bound checker at time %0t", $time);
            $display("Checks failed");
            $fatal(1, "assertion failed");
        end
    end

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // register-source uop, random op and destination
    function automatic int_rs_pkg::int_uop_t make_uop(input int_rs_pkg::phy_t rs1,
            input logic rs1_v, input int_rs_pkg::phy_t rs2, input logic rs2_v);
        int_rs_pkg::int_uop_t u;
        logic [31:0]          r;
        u = '0;
        r = rand_bits(`OP_W);
        u.op = r[`OP_W-1:0];
        r = rand_bits(`PHY_W);
        u.rd_phy = r[`PHY_W-1:0];
        u.rs1_phy = rs1;
        u.rs1_valid = rs1_v;
        u.src2.tag.rs2_phy = rs2;
        u.src2.tag.rs2_valid = rs2_v;
        return u;
    endfunction

    function automatic int_rs_pkg::int_uop_t make_imm_uop(input int_rs_pkg::phy_t rs1,
            input logic [`IMM_W-1:0] imm);
        int_rs_pkg::int_uop_t u;
        u = make_uop(rs1, 1'b1, '0, 1'b0);
        u.use_imm = 1'b1;
        u.src2.imm = imm;
        return u;
    endfunction

    // lane bits low, fast path on top
    function automatic int_rs_pkg::bypass_t make_byp(input logic [`BYP_W-1:0] r1,
            input logic [`BYP_W-1:0] r2);
        int_rs_pkg::bypass_t b;
        b.rs1_bypass_en = r1;
        b.rs2_bypass_en = r2;
        return b;
    endfunction

    task automatic check_val(input string name, input logic [63:0] actual,
            input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t while waiting for %s", $time, what);
        $display("Checks failed");
        $fatal(1, "wait limit reached");
    endtask

    // new cycle at the falling edge, wakeups last one cycle only
    task automatic begin_cycle();
        @(negedge clk);
        dispatch_valid = 1'b0;
        cdb_valid      = '0;
        cdb_tag        = '0;
        fast_valid     = 1'b0;
        fast_tag       = '0;
        issue_ready    = ready_next;
    endtask

    // settle point for checks, well before the rising edge
    task automatic idle_cycle();
        begin_cycle();
        #5;
    endtask

    task automatic broadcast_cdb(input logic v0, input int_rs_pkg::phy_t t0,
            input logic v1, input int_rs_pkg::phy_t t1,
            input logic fv, input int_rs_pkg::phy_t ft);
        begin_cycle();
        cdb_valid  = {v1, v0};
        cdb_tag[0] = t0;
        cdb_tag[1] = t1;
        fast_valid = fv;
        fast_tag   = ft;
        #5;
    endtask

    // returns in the cycle whose rising edge takes the uop
    task automatic do_dispatch(input int_rs_pkg::int_uop_t u);
        int waited;
        waited = 0;
        begin_cycle();
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        #5;
        while (!dispatch_ready) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("dispatch_ready");
            end
            @(negedge clk);
            #5;
            waited++;
        end
    endtask

    // offer a uop to a full station for one cycle
    task automatic offer_blocked(input int_rs_pkg::int_uop_t u);
        begin_cycle();
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        #5;
        check_val("dispatch_ready", dispatch_ready, 1'b0);
    endtask

    // checks in the current cycle first, max_wait more cycles after that
    task automatic expect_issue(input int_rs_pkg::int_uop_t u, input int_rs_pkg::bypass_t b,
            input int max_wait);
        int waited;
        waited = 0;
        while (!issue_valid) begin
            if (waited >= max_wait) begin
                report_timeout("issue_valid");
            end
            idle_cycle();
            waited++;
        end
        check_val("issue_uop.op", issue_uop.op, u.op);
        check_val("issue_uop.rd_phy", issue_uop.rd_phy, u.rd_phy);
        check_val("issue_uop.rs1_phy", issue_uop.rs1_phy, u.rs1_phy);
        check_val("issue_uop.rs1_valid", issue_uop.rs1_valid, u.rs1_valid);
        check_val("issue_uop.use_imm", issue_uop.use_imm, u.use_imm);
        check_val("issue_uop.src2", issue_uop.src2.imm, u.src2.imm);
        check_val("issue_bypass.rs1_bypass_en", issue_bypass.rs1_bypass_en, b.rs1_bypass_en);
        check_val("issue_bypass.rs2_bypass_en", issue_bypass.rs2_bypass_en, b.rs2_bypass_en);
    endtask

    // ready sources, on the port one cycle after acceptance
    task automatic ready_uop_issues();
        int_rs_pkg::int_uop_t u;
        u = make_uop(6'd3, 1'b1, 6'd4, 1'b1);
        do_dispatch(u);
        idle_cycle();
        expect_issue(u, '0, 0);
        idle_cycle();
        check_val("issue_valid", issue_valid, 1'b0);
    endtask

    task automatic wakeup_by_cdb();
        int_rs_pkg::int_uop_t u;
        int_rs_pkg::int_uop_t x;
        int_rs_pkg::int_uop_t y;
        u = make_uop(6'd5, 1'b0, 6'd9, 1'b0);
        do_dispatch(u);
        repeat (2) begin
            idle_cycle();
            check_val("issue_valid", issue_valid, 1'b0);
        end
        broadcast_cdb(1'b1, 6'd5, 1'b0, 6'd0, 1'b0, 6'd0);
        check_val("issue_valid", issue_valid, 1'b0);
        // last tag on lane 1, issue by bypass this cycle
        broadcast_cdb(1'b0, 6'd0, 1'b1, 6'd9, 1'b0, 6'd0);
        u.rs1_valid = 1'b1;
        u.src2.tag.rs2_valid = 1'b1;
        expect_issue(u, make_byp(3'b000, 3'b010), 0);
        // fast tag wakes x only in its own cycle
        x = make_uop(6'd7, 1'b0, 6'd0, 1'b1);
        y = make_uop(6'd7, 1'b0, 6'd20, 1'b0);
        do_dispatch(x);
        do_dispatch(y);
        idle_cycle();
        check_val("issue_valid", issue_valid, 1'b0);
        broadcast_cdb(1'b0, 6'd0, 1'b0, 6'd0, 1'b1, 6'd7);
        expect_issue(x, make_byp(3'b100, 3'b000), 0);
        // y saw the fast tag too but kept nothing from it
        broadcast_cdb(1'b1, 6'd20, 1'b0, 6'd0, 1'b0, 6'd0);
        check_val("issue_valid", issue_valid, 1'b0);
        broadcast_cdb(1'b0, 6'd0, 1'b1, 6'd7, 1'b0, 6'd0);
        y.rs1_valid = 1'b1;
        y.src2.tag.rs2_valid = 1'b1;
        expect_issue(y, make_byp(3'b010, 3'b000), 0);
    endtask

    // immediate low bits read as tag 12 or 13, not valid
    task automatic imm_not_a_tag();
        int_rs_pkg::int_uop_t u;
        u = make_imm_uop(6'd2, 12'h00c);
        do_dispatch(u);
        idle_cycle();
        expect_issue(u, '0, 0);
        u = make_imm_uop(6'd3, 12'h00d);
        do_dispatch(u);
        broadcast_cdb(1'b1, 6'd13, 1'b1, 6'd13, 1'b1, 6'd13);
        expect_issue(u, '0, 0);
    endtask

    task automatic age_order_when_full();
        int_rs_pkg::int_uop_t u;
        int_rs_pkg::int_uop_t exp_q[$];
        for (int i = 0; i < `RS_DEPTH; i++) begin
            u = make_uop(6'd30, 1'b0, 6'd0, 1'b1);
            do_dispatch(u);
            u.rs1_valid = 1'b1;
            exp_q.push_back(u);
        end
        idle_cycle();
        check_val("dispatch_ready", dispatch_ready, 1'b0);
        offer_blocked(make_uop(6'd1, 1'b1, 6'd0, 1'b1));
        // one tag wakes every slot at once
        broadcast_cdb(1'b1, 6'd30, 1'b0, 6'd0, 1'b0, 6'd0);
        expect_issue(exp_q.pop_front(), make_byp(3'b001, 3'b000), 0);
        idle_cycle();
        check_val("dispatch_ready", dispatch_ready, 1'b1);
        expect_issue(exp_q.pop_front(), '0, 0);
        idle_cycle();
        expect_issue(exp_q.pop_front(), '0, 0);
        // younger uops land in low slots, must still wait their turn
        ready_next = 1'b0;
        repeat (2) begin
            u = make_uop(6'd2, 1'b1, 6'd3, 1'b1);
            do_dispatch(u);
            exp_q.push_back(u);
        end
        ready_next = 1'b1;
        while (exp_q.size() > 0) begin
            idle_cycle();
            expect_issue(exp_q.pop_front(), '0, 0);
        end
        idle_cycle();
        check_val("issue_valid", issue_valid, 1'b0);
    endtask

    task automatic back_pressure_hold();
        int_rs_pkg::int_uop_t p;
        int_rs_pkg::int_uop_t q;
        p = make_uop(6'd11, 1'b1, 6'd12, 1'b1);
        q = make_uop(6'd13, 1'b1, 6'd14, 1'b1);
        ready_next = 1'b0;
        do_dispatch(p);
        do_dispatch(q);
        repeat (3) begin
            idle_cycle();
            check_val("issue_valid", issue_valid, 1'b1);
            check_val("issue_uop", issue_uop, p);
        end
        ready_next = 1'b1;
        idle_cycle();
        expect_issue(p, '0, 0);
        idle_cycle();
        expect_issue(q, '0, 0);
        idle_cycle();
        check_val("issue_valid", issue_valid, 1'b0);
    endtask

    // rs1 is the zero register, marked valid by dispatch
    task automatic tag_zero_never_matches();
        int_rs_pkg::int_uop_t z;
        z = make_uop(6'd0, 1'b1, 6'd33, 1'b0);
        do_dispatch(z);
        broadcast_cdb(1'b1, 6'd0, 1'b1, 6'd0, 1'b1, 6'd0);
        check_val("issue_valid", issue_valid, 1'b0);
        broadcast_cdb(1'b1, 6'd0, 1'b1, 6'd33, 1'b1, 6'd0);
        z.src2.tag.rs2_valid = 1'b1;
        expect_issue(z, make_byp(3'b000, 3'b010), 0);
    endtask

    initial begin
        lfsr_state     = 32'hce8c;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        cdb_valid      = '0;
        cdb_tag        = '0;
        fast_valid     = 1'b0;
        fast_tag       = '0;
        ready_next     = 1'b1;
        issue_ready    = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #5;
        check_val("issue_valid", issue_valid, 1'b0);
        check_val("dispatch_ready", dispatch_ready, 1'b1);
        ready_uop_issues();
        wakeup_by_cdb();
        imm_not_a_tag();
        age_order_when_full();
        back_pressure_hold();
        tag_zero_never_matches();
        $display("All checks passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+hw
hw/int_rs_pkg.sv
hw/rs_entry.sv
hw/rs_age_select.sv
hw/int_rs.sv
testbench/int_rs_sva.sv
testbench/int_rs_tb.sv
